// File: verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // ------------------------------------------------------------
    // widths and sizes
    // ------------------------------------------------------------
    localparam int unsigned XLEN        = 32;
    localparam int unsigned REG_AW      = 5;
    localparam int unsigned QUEUE_DEPTH = 4;
    localparam int unsigned QUEUE_AW    = $clog2(QUEUE_DEPTH);

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_idx_t;

    // first fetch address
    localparam word_t RESET_PC = '0;

    // ------------------------------------------------------------
    // opcodes and function codes
    // ------------------------------------------------------------
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    // ------------------------------------------------------------
    // instruction word views
    // ------------------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } inst_i_t;

    // same 32 bits, register-register or register-immediate layout
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

endpackage

`default_nettype wire

// File: verilog/inst_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface inst_stream_if;
    import rv_pkg::*;

    logic  valid;
    word_t inst;
    word_t pc;
    logic  ready;

    // transfer on a rising edge with valid and ready both high
    modport producer (output valid, output inst, output pc, input ready);
    modport consumer (input valid, input inst, input pc, output ready);

endinterface

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire rv_pkg::alu_op_t op_i,
    input  wire rv_pkg::word_t   a_i,
    input  wire rv_pkg::word_t   b_i,
    output rv_pkg::word_t        y_o
);
    import rv_pkg::*;

    logic [4:0] shamt;

    // only the low five bits shift
    assign shamt = b_i[4:0];

    always_comb begin
        case (op_i)
            ALU_ADD:  y_o = a_i + b_i;
            ALU_SUB:  y_o = a_i - b_i;
            ALU_SLL:  y_o = a_i << shamt;
            ALU_SLT:  y_o = {{(XLEN-1){1'b0}}, ($signed(a_i) < $signed(b_i))};
            ALU_SLTU: y_o = {{(XLEN-1){1'b0}}, (a_i < b_i)};
            ALU_XOR:  y_o = a_i ^ b_i;
            ALU_SRL:  y_o = a_i >> shamt;
            ALU_SRA:  y_o = word_t'($signed(a_i) >>> shamt);
            ALU_OR:   y_o = a_i | b_i;
            ALU_AND:  y_o = a_i & b_i;
            default:  y_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic             clk,
    input  wire rv_pkg::reg_idx_t rs1_i,
    input  wire rv_pkg::reg_idx_t rs2_i,
    output rv_pkg::word_t         rs1_data_o,
    output rv_pkg::word_t         rs2_data_o,
    input  wire logic             we_i,
    input  wire rv_pkg::reg_idx_t rd_i,
    input  wire rv_pkg::word_t    rd_data_i
);
    import rv_pkg::*;

    word_t regs [2**REG_AW];

    // write lands at the edge, visible to the next read
    always_ff @(posedge clk) begin
        if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    // x0 is hardwired
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire logic           clk,
    input  wire logic           rst,
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output rv_pkg::word_t       wb_adr_o,
    input  wire rv_pkg::word_t  wb_dat_i,
    input  wire logic           wb_ack_i,
    inst_stream_if.producer     out
);
    import rv_pkg::*;

    word_t pc_q;
    logic  cyc_q;
    logic  hold_valid_q;
    word_t hold_inst_q;
    word_t hold_pc_q;
    logic  accept;

    assign accept = hold_valid_q && out.ready;

    // ------------------------------------------------------------
    // bus cycle and holding register control
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q         <= RESET_PC;
            cyc_q        <= 1'b0;
            hold_valid_q <= 1'b0;
        end else begin
            // one read at a time, only with an empty holding register
            if (!cyc_q && !hold_valid_q) begin
                cyc_q <= 1'b1;
            end else if (cyc_q && wb_ack_i) begin
                cyc_q        <= 1'b0;
                hold_valid_q <= 1'b1;
            end else if (accept) begin
                hold_valid_q <= 1'b0;
                pc_q         <= pc_q + XLEN'(4);
            end
        end
    end

    // word and its address, captured in the ack cycle
    always_ff @(posedge clk) begin
        if (cyc_q && wb_ack_i) begin
            hold_inst_q <= wb_dat_i;
            hold_pc_q   <= pc_q;
        end
    end

    assign wb_cyc_o  = cyc_q;
    assign wb_stb_o  = cyc_q;
    assign wb_adr_o  = pc_q;
    assign out.valid = hold_valid_q;
    assign out.inst  = hold_inst_q;
    assign out.pc    = hold_pc_q;

    // request held with a stable address until the slave acks
    a_stb_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o)));

endmodule

`default_nettype wire

// File: verilog/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue (
    input  wire logic       clk,
    input  wire logic       rst,
    inst_stream_if.consumer in,
    inst_stream_if.producer out
);
    import rv_pkg::*;

    word_t               mem_inst [QUEUE_DEPTH];
    word_t               mem_pc   [QUEUE_DEPTH];
    logic [QUEUE_AW-1:0] wr_ptr_q;
    logic [QUEUE_AW-1:0] rd_ptr_q;
    logic [QUEUE_AW:0]   count_q;
    logic                push;
    logic                pop;

    assign in.ready  = (count_q != (QUEUE_AW+1)'(QUEUE_DEPTH));
    assign out.valid = (count_q != '0);
    assign push      = in.valid && in.ready;
    assign pop       = out.valid && out.ready;

    // ------------------------------------------------------------
    // pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // storage with pointers that wrap at the power-of-two depth
    always_ff @(posedge clk) begin
        if (push) begin
            mem_inst[wr_ptr_q] <= in.inst;
            mem_pc[wr_ptr_q]   <= in.pc;
        end
    end

    assign out.inst = mem_inst[rd_ptr_q];
    assign out.pc   = mem_pc[rd_ptr_q];

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        count_q <= (QUEUE_AW+1)'(QUEUE_DEPTH));

    // from empty the count can only stay or step up by one
    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        (count_q == '0) |=> (count_q <= (QUEUE_AW+1)'(1)));

endmodule

`default_nettype wire

// File: verilog/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  wire logic         clk,
    input  wire logic         rst,
    inst_stream_if.consumer   in,
    output logic              retire_valid_o,
    output rv_pkg::word_t     retire_pc_o,
    output rv_pkg::reg_idx_t  retire_rd_o,
    output rv_pkg::word_t     retire_data_o
);
    import rv_pkg::*;

    inst_u   inst_w;
    word_t   rs1_data;
    word_t   rs2_data;
    word_t   imm_ext;
    word_t   op_b;
    word_t   alu_y;
    alu_op_t alu_op;
    logic    is_op;
    logic    is_op_imm;
    logic    pop;
    logic    rf_we;

    // single-cycle execute, never stalls
    assign in.ready = 1'b1;
    assign pop      = in.valid && in.ready;

    // ------------------------------------------------------------
    // decode
    // ------------------------------------------------------------
    assign inst_w    = in.inst;
    assign is_op     = (inst_w.r.opcode == OPC_OP);
    assign is_op_imm = (inst_w.i.opcode == OPC_OP_IMM);
    assign imm_ext   = {{(XLEN-12){inst_w.i.imm[11]}}, inst_w.i.imm};
    assign op_b      = is_op ? rs2_data : imm_ext;

    always_comb begin
        case (inst_w.r.funct3)
            // no subtract-immediate, bit 5 only counts for OP
            F3_ADD_SUB: alu_op = (is_op && inst_w.r.funct7[5]) ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_op = ALU_SLL;
            F3_SLT:     alu_op = ALU_SLT;
            F3_SLTU:    alu_op = ALU_SLTU;
            F3_XOR:     alu_op = ALU_XOR;
            F3_SRL_SRA: alu_op = inst_w.r.funct7[5] ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_op = ALU_OR;
            default:    alu_op = ALU_AND;
        endcase
    end

    // unsupported opcodes retire without touching the register file
    assign rf_we = pop && (is_op || is_op_imm);

    reg_file u_reg_file (
        .clk        (clk),
        .rs1_i      (inst_w.r.rs1),
        .rs2_i      (inst_w.r.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .rd_i       (inst_w.r.rd),
        .rd_data_i  (alu_y)
    );

    alu u_alu (
        .op_i (alu_op),
        .a_i  (rs1_data),
        .b_i  (op_b),
        .y_o  (alu_y)
    );

    // ------------------------------------------------------------
    // retire report, one cycle after the pop
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid_o <= 1'b0;
        end else begin
            retire_valid_o <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            retire_pc_o   <= in.pc;
            retire_rd_o   <= inst_w.r.rd;
            retire_data_o <= alu_y;
        end
    end

endmodule

`default_nettype wire

// File: verilog/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  wire logic             clk,
    input  wire logic             rst,
    // wishbone instruction fetch
    output logic                  wb_cyc_o,
    output logic                  wb_stb_o,
    output rv_pkg::word_t         wb_adr_o,
    input  wire rv_pkg::word_t    wb_dat_i,
    input  wire logic             wb_ack_i,
    // retire report
    output logic                  retire_valid_o,
    output rv_pkg::word_t         retire_pc_o,
    output rv_pkg::reg_idx_t      retire_rd_o,
    output rv_pkg::word_t         retire_data_o
);

    inst_stream_if fetch_q ();
    inst_stream_if q_exec ();

    fetch_unit u_fetch (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc_o (wb_cyc_o),
        .wb_stb_o (wb_stb_o),
        .wb_adr_o (wb_adr_o),
        .wb_dat_i (wb_dat_i),
        .wb_ack_i (wb_ack_i),
        .out      (fetch_q.producer)
    );

    inst_queue u_queue (
        .clk (clk),
        .rst (rst),
        .in  (fetch_q.consumer),
        .out (q_exec.producer)
    );

    exec_unit u_exec (
        .clk            (clk),
        .rst            (rst),
        .in             (q_exec.consumer),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release just after an edge, like the other stimulus
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/tb_imem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_imem #(
    parameter int unsigned WORDS = 128
) (
    input  wire logic          clk_i,
    input  wire logic          rst_i,
    input  wire logic          cyc_i,
    input  wire logic          stb_i,
    input  wire rv_pkg::word_t adr_i,
    output rv_pkg::word_t      dat_o,
    output logic               ack_o
);
    import rv_pkg::*;

    localparam int unsigned AW = $clog2(WORDS);

    // loaded by the testbench top before reset is released
    word_t mem [WORDS];

    logic  pending;
    int    wait_left;
    logic  ack_next;
    word_t dat_next;

    initial begin
        ack_o     = 1'b0;
        dat_o     = '0;
        pending   = 1'b0;
        wait_left = 0;
    end

    // ------------------------------------------------------------
    // classic slave, ack after 0 to 3 extra cycles
    // ------------------------------------------------------------
    always @(posedge clk_i) begin
        ack_next = 1'b0;
        dat_next = dat_o;
        if (rst_i) begin
            pending = 1'b0;
        end else if (cyc_i && stb_i && !ack_o) begin
            // new request, draw its delay once
            if (!pending) begin
                pending   = 1'b1;
                wait_left = $urandom_range(3, 0);
            end
            if (wait_left == 0) begin
                pending  = 1'b0;
                ack_next = 1'b1;
                dat_next = mem[adr_i[AW+1:2]];
            end else begin
                wait_left = wait_left - 1;
            end
        end
        #2;
        ack_o = ack_next;
        dat_o = dat_next;
    end

endmodule

`default_nettype wire

// File: verification/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import rv_pkg::*;

    localparam int PROG_LEN        = 64;
    localparam int IMEM_WORDS      = 128;
    localparam int IMEM_AW         = 7;
    localparam int CLK_PERIOD_NS   = 20;
    localparam int WATCHDOG_CYCLES = (PROG_LEN + 16) * 6;

    logic     clk;
    logic     rst;
    logic     wb_cyc;
    logic     wb_stb;
    word_t    wb_adr;
    word_t    wb_dat;
    logic     wb_ack;
    logic     ret_valid;
    word_t    ret_pc;
    reg_idx_t ret_rd;
    word_t    ret_data;

    word_t    image [IMEM_WORDS];
    word_t    model_regs [32];
    inst_u    cur;
    word_t    exp_pc;
    reg_idx_t exp_rd;
    word_t    exp_data;
    word_t    exp_adr;
    int       retired    = 0;
    int       value_errs = 0;
    int       proto_errs = 0;

    tb_clk_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(10)) u_clk_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    tb_imem #(.WORDS(IMEM_WORDS)) u_imem (
        .clk_i (clk),
        .rst_i (rst),
        .cyc_i (wb_cyc),
        .stb_i (wb_stb),
        .adr_i (wb_adr),
        .dat_o (wb_dat),
        .ack_o (wb_ack)
    );

    core_top uut (
        .clk            (clk),
        .rst            (rst),
        .wb_cyc_o       (wb_cyc),
        .wb_stb_o       (wb_stb),
        .wb_adr_o       (wb_adr),
        .wb_dat_i       (wb_dat),
        .wb_ack_i       (wb_ack),
        .retire_valid_o (ret_valid),
        .retire_pc_o    (ret_pc),
        .retire_rd_o    (ret_rd),
        .retire_data_o  (ret_data)
    );

    // ------------------------------------------------------------
    // program generation
    // ------------------------------------------------------------
    // x1..x7 start unknown in the DUT, so the first seven words load them
    function automatic word_t gen_inst(input int idx);
        inst_u      w;
        logic [2:0] f3;
        logic       alt;
        w   = '0;
        f3  = 3'(idx);
        alt = idx[4];
        if (idx < 7) begin
            w.i.opcode = OPC_OP_IMM;
            w.i.rd     = reg_idx_t'(idx + 1);
            w.i.imm    = 12'($urandom);
        end else if (idx[3]) begin
            w.r.opcode = OPC_OP;
            w.r.funct3 = f3;
            w.r.rd     = reg_idx_t'($urandom_range(7, 0));
            w.r.rs1    = reg_idx_t'($urandom_range(7, 0));
            w.r.rs2    = reg_idx_t'($urandom_range(7, 0));
            if ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && alt) begin
                w.r.funct7 = 7'b0100000;
            end
        end else begin
            w.i.opcode = OPC_OP_IMM;
            w.i.funct3 = f3;
            w.i.rd     = reg_idx_t'($urandom_range(7, 0));
            w.i.rs1    = reg_idx_t'($urandom_range(7, 0));
            w.i.imm    = 12'($urandom);
            // shifts carry only shamt plus the arithmetic bit
            if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
                w.i.imm[11:5] = (f3 == F3_SRL_SRA && alt) ? 7'b0100000 : 7'b0;
            end
        end
        return w;
    endfunction

    // addi x0, x0, index
    function automatic word_t nop_word(input int idx);
        inst_u w;
        w          = '0;
        w.i.opcode = OPC_OP_IMM;
        w.i.imm    = 12'(idx);
        return w;
    endfunction

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic word_t model_exec(input inst_u w, input word_t a, input word_t r2);
        word_t              b;
        word_t              y;
        logic               alt;
        logic [4:0]         sh;
        logic signed [31:0] sa;
        logic signed [31:0] sb;
        if (w.r.opcode == OPC_OP) begin
            b   = r2;
            alt = w.r.funct7[5];
        end else begin
            b   = {{20{w.i.imm[11]}}, w.i.imm};
            // no subtract immediate, only srai looks at bit 10
            alt = (w.i.funct3 == F3_SRL_SRA) && w.i.imm[10];
        end
        sh = b[4:0];
        sa = a;
        sb = b;
        case (w.r.funct3)
            F3_ADD_SUB: y = alt ? a - b : a + b;
            F3_SLL:     y = a << sh;
            F3_SLT:     y = (sa < sb) ? 32'd1 : 32'd0;
            F3_SLTU:    y = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     y = a ^ b;
            F3_SRL_SRA: begin
                if (alt) begin
                    y = sa >>> sh;
                end else begin
                    y = a >> sh;
                end
            end
            F3_OR:      y = a | b;
            default:    y = a & b;
        endcase
        return y;
    endfunction

    // program order, expectation for the next retire ready one edge ahead
    always @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < 32; k++) begin
                model_regs[k] = '0;
            end
            exp_pc  = RESET_PC;
            retired = 0;
        end else if (ret_valid) begin
            if (exp_rd != '0) begin
                model_regs[exp_rd] = exp_data;
            end
            exp_pc  = exp_pc + 32'd4;
            retired = retired + 1;
        end
        cur      = image[exp_pc[IMEM_AW+1:2]];
        exp_rd   = cur.r.rd;
        exp_data = model_exec(cur, model_regs[cur.r.rs1], model_regs[cur.r.rs2]);
    end

    always @(posedge clk) begin
        if (rst) begin
            exp_adr <= RESET_PC;
        end else if (wb_cyc && wb_stb && wb_ack) begin
            exp_adr <= exp_adr + 32'd4;
        end
    end

    // ------------------------------------------------------------
    // assertions
    // ------------------------------------------------------------
    a_reset_idle: assert property (@(posedge clk)
        rst |=> (!wb_cyc && !wb_stb && !ret_valid))
    else begin
        proto_errs = proto_errs + 1;
        $display("bus request or retire active during reset at %0t", $time);
    end

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
    else begin
        proto_errs = proto_errs + 1;
        $display("wb_stb_o high without wb_cyc_o at %0t", $time);
    end

    a_adr_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
    else begin
        proto_errs = proto_errs + 1;
        $display("bus request dropped or address changed before ack at %0t", $time);
    end

    a_adr_seq: assert property (@(posedge clk) disable iff (rst) wb_stb |-> (wb_adr == exp_adr))
    else begin
        value_errs = value_errs + 1;
        $display("ERR %0t: bus address %h, expected %h", $time, $sampled(wb_adr),
                 $sampled(exp_adr));
    end

    a_retire_pc: assert property (@(posedge clk) disable iff (rst)
        ret_valid |-> (ret_pc == exp_pc))
    else begin
        value_errs = value_errs + 1;
        $display("ERR %0t: retire pc %h, expected %h", $time, $sampled(ret_pc),
                 $sampled(exp_pc));
    end

    a_retire_rd: assert property (@(posedge clk) disable iff (rst)
        ret_valid |-> (ret_rd == exp_rd))
    else begin
        value_errs = value_errs + 1;
        $display("ERR %0t: retire rd x%0d, expected x%0d", $time, $sampled(ret_rd),
                 $sampled(exp_rd));
    end

    a_retire_data: assert property (@(posedge clk) disable iff (rst)
        ret_valid |-> (ret_data == exp_data))
    else begin
        value_errs = value_errs + 1;
        $display("ERR %0t: retire data %h at pc %h, expected %h", $time,
                 $sampled(ret_data), $sampled(ret_pc), $sampled(exp_data));
    end

    // ------------------------------------------------------------
    // run control
    // ------------------------------------------------------------
    initial begin
        void'($urandom(62));
        for (int i = 0; i < IMEM_WORDS; i++) begin
            image[i] = (i < PROG_LEN) ? gen_inst(i) : nop_word(i);
            u_imem.mem[i] = image[i];
        end
        wait (retired >= PROG_LEN);
        @(posedge clk);
        #1;
        $display("retired %0d of %0d, value errors %0d, protocol errors %0d",
                 retired, PROG_LEN, value_errs, proto_errs);
        if (value_errs + proto_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("watchdog expired after %0d cycles with %0d of %0d instructions retired",
                 WATCHDOG_CYCLES, retired, PROG_LEN);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
verilog/rv_pkg.sv
verilog/inst_stream_if.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/fetch_unit.sv
verilog/inst_queue.sv
verilog/exec_unit.sv
verilog/core_top.sv
verification/tb_clk_gen.sv
verification/tb_imem.sv
verification/tb_top.sv
